/* x2pBridge.f */
common/x2pPkg.sv
logic/syncFifo.sv
logic/burstArbiter.sv
logic/addrDecoder.sv
logic/apbMaster.sv
logic/respBuilder.sv
logic/x2pBridge.sv
verif/x2pBridge_props.sv
verif/x2pBridgeTb.sv

/* Makefile */
# Verilator build and run of the AXI to APB bridge testbench

VERILATOR ?= verilator
TOP       ?= x2pBridgeTb
FILELIST  ?= x2pBridge.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verif/x2pBridgeTb.sv */
`timescale 1ns/1ps

module x2pBridgeTb;

  import x2pPkg::*;

  localparam int               fifoDepthLog2 = 2;
  localparam int               slaveNum      = 4;
  localparam logic [addrW-1:0] slaveBase     = 32'h4000_0000;
  localparam logic [addrW-1:0] slaveSpan     = 32'h0000_1000;
  localparam int               readyTimeout  = 4000;
  localparam int               drainTimeout  = 40000;

  logic                          pclk = 1'b0;
  logic                          preset_n;
  logic                          awvalid;
  logic                          awready;
  logic [addrW-1:0]              awaddr;
  logic [lenW-1:0]               awlen;
  logic [idW-1:0]                awid;
  logic [2:0]                    awprot;
  logic                          wvalid;
  logic                          wready;
  logic [dataW-1:0]              wdata;
  logic [strbW-1:0]              wstrb;
  logic                          arvalid;
  logic                          arready;
  logic [addrW-1:0]              araddr;
  logic [lenW-1:0]               arlen;
  logic [idW-1:0]                arid;
  logic [2:0]                    arprot;
  logic                          rvalid;
  logic                          rready;
  logic [dataW-1:0]              rdata;
  resp_t                         rresp;
  logic [idW-1:0]                rid;
  logic                          rlast;
  logic                          bvalid;
  logic                          bready;
  resp_t                         bresp;
  logic [idW-1:0]                bid;
  logic [slaveNum-1:0]           psel;
  logic                          penable;
  logic [addrW-1:0]              paddr;
  logic                          pwrite;
  logic [dataW-1:0]              pwdata;
  logic [strbW-1:0]              pstrb;
  logic [2:0]                    pprot;
  logic [slaveNum-1:0]           pready;
  logic [slaveNum-1:0]           pslverr;
  logic [slaveNum-1:0][dataW-1:0] prdata;

  logic [31:0]      stimLfsr = 32'h9c450bdd;
  logic [31:0]      busLfsr  = 32'h9c450bdd;
  logic             backPressure = 1'b0;
  string            testName;
  logic [dataW-1:0] slaveMem [logic [addrW-1:0]];
  logic [dataW-1:0] shadow [logic [addrW-1:0]];
  rBeat_t           expR [$];
  // {id, resp} per expected write response
  logic [idW+1:0]   expB [$];
  // expected pprot per APB beat, one queue per direction
  logic [2:0]       protW [$];
  logic [2:0]       protR [$];
  logic             accessSeen = 1'b0;

  x2pBridge #(
    .fifoDepthLog2(fifoDepthLog2),
    .slaveNum     (slaveNum),
    .slaveBase    (slaveBase),
    .slaveSpan    (slaveSpan)
  ) x2pBridge_inst (.*);

  always #2 pclk = ~pclk;

  // ==========================================================================
  // random bits and reference model
  // ==========================================================================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] stimBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      stimLfsr = lfsrNext(stimLfsr);
      v = {v[30:0], stimLfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] busBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      busLfsr = lfsrNext(busLfsr);
      v = {v[30:0], busLfsr[0]};
    end
    return v;
  endfunction

  function automatic logic inWindows(input logic [addrW-1:0] a);
    return a >= slaveBase && a < slaveBase + 32'(slaveNum) * slaveSpan;
  endfunction

  // top 64 words of every window answer with a slave error
  function automatic logic inErrRegion(input logic [addrW-1:0] a);
    logic [addrW-1:0] offs;
    offs = a - slaveBase;
    return offs[11:8] == 4'hf;
  endfunction

  function automatic logic [slaveNum-1:0] expectSel(input logic [addrW-1:0] a);
    if (!inWindows(a)) begin
      return '0;
    end
    return slaveNum'(1) << ((a - slaveBase) / slaveSpan);
  endfunction

  function automatic logic [dataW-1:0] modelWord(input logic [addrW-1:0] a);
    return slaveMem.exists(a) ? slaveMem[a] : a;
  endfunction

  function automatic logic [dataW-1:0] shadowWord(input logic [addrW-1:0] a);
    return shadow.exists(a) ? shadow[a] : a;
  endfunction

  function automatic rBeat_t refRead(input logic [addrW-1:0] a);
    rBeat_t r;
    r = '0;
    if (!inWindows(a)) begin
      r.resp = DECERR;
    end else begin
      r.data = shadowWord(a);
      r.resp = inErrRegion(a) ? SLVERR : OKAY;
    end
    return r;
  endfunction

  function automatic resp_t refWrite(input logic [addrW-1:0] a, input logic [dataW-1:0] d,
                                     input logic [strbW-1:0] s);
    logic [dataW-1:0] w;
    if (!inWindows(a)) begin
      return DECERR;
    end
    if (inErrRegion(a)) begin
      return SLVERR;
    end
    w = shadowWord(a);
    for (int b = 0; b < strbW; b++) begin
      if (s[b]) begin
        w[8*b +: 8] = d[8*b +: 8];
      end
    end
    shadow[a] = w;
    return OKAY;
  endfunction

  // ==========================================================================
  // checks and AXI driver
  // ==========================================================================

  task automatic abortRun();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
      abortRun();
    end
  endtask

  // chan 0 is AW, 1 is W, 2 is AR
  task automatic waitReady(input int chan, input string what);
    int waited;
    waited = 0;
    while (!(chan == 0 ? awready : (chan == 1 ? wready : arready))) begin
      waited++;
      if (waited > readyTimeout) begin
        $display("timeout in %s waiting for %s", testName, what);
        abortRun();
      end
      @(posedge pclk);
      #1;
    end
    @(posedge pclk);
    #1;
  endtask

  task automatic waitIdle();
    int waited;
    waited = 0;
    while (expR.size() != 0 || expB.size() != 0) begin
      waited++;
      if (waited > drainTimeout) begin
        $display("timeout in %s, responses still outstanding", testName);
        abortRun();
      end
      @(posedge pclk);
      #1;
    end
  endtask

  task automatic writeBurst(input logic [addrW-1:0] addr, input int beats,
                            input logic [idW-1:0] id, input logic fullStrb);
    resp_t            worst;
    resp_t            r;
    logic [dataW-1:0] d;
    logic [strbW-1:0] s;
    worst = OKAY;
    awaddr = addr;
    awlen = lenW'(beats - 1);
    awid = id;
    awprot = 3'(stimBits(3));
    awvalid = 1'b1;
    waitReady(0, "awready");
    awvalid = 1'b0;
    for (int i = 0; i < beats; i++) begin
      d = stimBits(32);
      s = fullStrb ? 4'hf : 4'(stimBits(4));
      r = refWrite(addr + 32'(4 * i), d, s);
      // severity follows the AXI encoding order
      if (r > worst) begin
        worst = r;
      end
      protW.push_back(awprot);
      wdata = d;
      wstrb = s;
      wvalid = 1'b1;
      waitReady(1, "wready");
      wvalid = 1'b0;
    end
    expB.push_back({id, worst});
  endtask

  task automatic readBurst(input logic [addrW-1:0] addr, input int beats,
                           input logic [idW-1:0] id);
    rBeat_t want;
    arprot = 3'(stimBits(3));
    for (int i = 0; i < beats; i++) begin
      want = refRead(addr + 32'(4 * i));
      want.id = id;
      want.last = i == beats - 1;
      expR.push_back(want);
      protR.push_back(arprot);
    end
    araddr = addr;
    arlen = lenW'(beats - 1);
    arid = id;
    arvalid = 1'b1;
    waitReady(2, "arready");
    arvalid = 1'b0;
  endtask

  // ==========================================================================
  // APB slave models and AXI response ready
  // ==========================================================================

  always @(posedge pclk) begin
    #1;
    rready = backPressure ? 1'(busBits(1)) : 1'b1;
    bready = backPressure ? 1'(busBits(1)) : 1'b1;
    for (int i = 0; i < slaveNum; i++) begin
      pready[i] = 1'(busBits(1));
      prdata[i] = $isunknown(paddr) ? '0 : modelWord(paddr);
      pslverr[i] = $isunknown(paddr) ? 1'b0 : inErrRegion(paddr);
    end
  end

  always @(negedge pclk) begin
    logic [dataW-1:0] word;
    logic [2:0]       wantProt;
    if (penable) begin
      check("psel", 32'(expectSel(paddr)), 32'(psel));
      // first ACCESS cycle of a beat
      if (!accessSeen) begin
        if ((pwrite && protW.size() == 0) || (!pwrite && protR.size() == 0)) begin
          $display("APB beat in %s with no burst outstanding", testName);
          abortRun();
        end
        if (pwrite) begin
          wantProt = protW.pop_front();
        end else begin
          wantProt = protR.pop_front();
        end
        check("pprot", 32'(wantProt), 32'(pprot));
      end
      if ((|(psel & pready)) && pwrite && !inErrRegion(paddr)) begin
        word = modelWord(paddr);
        for (int b = 0; b < strbW; b++) begin
          if (pstrb[b]) begin
            word[8*b +: 8] = pwdata[8*b +: 8];
          end
        end
        slaveMem[paddr] = word;
      end
    end
    accessSeen = penable;
  end

  // handshakes complete on the next rising edge
  always @(negedge pclk) begin
    rBeat_t         want;
    logic [idW+1:0] wantB;
    if (rvalid && rready) begin
      if (expR.size() == 0) begin
        $display("R beat arrived in %s with no read outstanding", testName);
        abortRun();
      end
      want = expR.pop_front();
      check("rdata", want.data, rdata);
      check("rresp", 32'(want.resp), 32'(rresp));
      check("rid", 32'(want.id), 32'(rid));
      check("rlast", 32'(want.last), 32'(rlast));
    end
    if (bvalid && bready) begin
      if (expB.size() == 0) begin
        $display("B response arrived in %s with no write outstanding", testName);
        abortRun();
      end
      wantB = expB.pop_front();
      check("bresp", 32'(wantB[1:0]), 32'(bresp));
      check("bid", 32'(wantB[idW+1:2]), 32'(bid));
    end
  end

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin
    int               beats;
    logic [addrW-1:0] offs;
    logic             pick;
    preset_n = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    awlen = '0;
    awid = '0;
    awprot = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    arvalid = 1'b0;
    araddr = '0;
    arlen = '0;
    arid = '0;
    arprot = '0;
    rready = 1'b0;
    bready = 1'b0;
    pready = '0;
    pslverr = '0;
    prdata = '0;
    repeat (8) begin
      @(posedge pclk);
    end
    #1;
    preset_n = 1'b1;

    testName = "reset";
    check("psel", 32'h0, 32'(psel));
    check("penable", 32'h0, 32'(penable));
    check("rvalid", 32'h0, 32'(rvalid));
    check("bvalid", 32'h0, 32'(bvalid));
    check("ready", 32'h7, 32'({awready, wready, arready}));

    testName = "single";
    writeBurst(slaveBase + 32'h10, 1, 8'h11, 1'b1);
    waitIdle();
    readBurst(slaveBase + 32'h10, 1, 8'h22);
    waitIdle();

    testName = "incr";
    beats = int'(stimBits(8)) + 1;
    writeBurst(slaveBase + 32'h1000, beats, 8'h31, 1'b1);
    waitIdle();
    readBurst(slaveBase + 32'h1000, beats, 8'h32);
    waitIdle();

    testName = "strobe";
    writeBurst(slaveBase + 32'h2100, 8, 8'h41, 1'b1);
    waitIdle();
    writeBurst(slaveBase + 32'h2100, 8, 8'h42, 1'b0);
    waitIdle();
    readBurst(slaveBase + 32'h2100, 8, 8'h43);
    waitIdle();

    testName = "decerr";
    writeBurst(32'h1000_0000, 2, 8'h51, 1'b1);
    readBurst(32'h1000_0000, 2, 8'h52);
    readBurst(slaveBase + 32'(slaveNum) * slaveSpan, 1, 8'h53);
    waitIdle();

    testName = "slverr";
    // last two beats fall in the error region
    writeBurst(slaveBase + 32'h3ef8, 4, 8'h61, 1'b1);
    waitIdle();
    readBurst(slaveBase + 32'h3ef8, 4, 8'h62);
    waitIdle();

    // writes to slave 2, reads from slave 1, so order between them is free
    testName = "stress";
    backPressure = 1'b1;
    for (int n = 0; n < 60; n++) begin
      pick = 1'(stimBits(1));
      beats = int'(stimBits(4)) + 1;
      offs = 32'(stimBits(8)) << 2;
      if (pick) begin
        writeBurst(slaveBase + 32'h2000 + offs, beats, idW'(n), 1'b0);
      end else begin
        readBurst(slaveBase + 32'h1000 + offs, beats, idW'(n));
      end
    end
    waitIdle();
    // every word the reference wrote must have reached a slave
    foreach (shadow[a]) begin
      check("memory", shadow[a], modelWord(a));
    end
    backPressure = 1'b0;
    repeat (20) begin
      @(posedge pclk);
    end

    $display("Test OK");
    $finish;
  end

endmodule

/* verif/x2pBridge_props.sv */
`timescale 1ns/1ps

module x2pBridge_props #(
  parameter int slaveNum = 4
) (
  input  logic                       pclk,
  input  logic                       preset_n,
  input  logic [slaveNum-1:0]        psel,
  input  logic                       penable,
  input  logic [slaveNum-1:0]        pready,
  input  logic [x2pPkg::addrW-1:0]   paddr,
  input  logic [x2pPkg::dataW-1:0]   pwdata
);

  logic waitState;

  // selected slave still inserting wait states
  assign waitState = penable & (|psel) & ~(|(psel & pready));

  pselOneHot: assert property (@(posedge pclk) disable iff (!preset_n)
    $onehot0(psel))
    else $error("psel has more than one slave selected");

  setupToAccess: assert property (@(posedge pclk) disable iff (!preset_n)
    (|psel && !penable) |=> penable)
    else $error("SETUP phase not followed by ACCESS");

  stableInWait: assert property (@(posedge pclk) disable iff (!preset_n)
    waitState |=> ($stable(paddr) && $stable(pwdata)))
    else $error("paddr or pwdata changed during a wait state");

endmodule

bind x2pBridge x2pBridge_props #(.slaveNum(slaveNum)) props (
  .pclk    (pclk),
  .preset_n(preset_n),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .paddr   (paddr),
  .pwdata  (pwdata)
);

/* logic/x2pBridge.sv */
`timescale 1ns/1ps

module x2pBridge #(
  parameter int                       fifoDepthLog2 = 2,
  parameter int                       slaveNum      = 4,
  parameter logic [x2pPkg::addrW-1:0] slaveBase     = 32'h4000_0000,
  parameter logic [x2pPkg::addrW-1:0] slaveSpan     = 32'h0000_1000
) (
  input  logic                                   pclk,
  input  logic                                   preset_n,
  // write address
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [x2pPkg::addrW-1:0]               awaddr,
  input  logic [x2pPkg::lenW-1:0]                awlen,
  input  logic [x2pPkg::idW-1:0]                 awid,
  input  logic [2:0]                             awprot,
  // write data
  input  logic                                   wvalid,
  output logic                                   wready,
  input  logic [x2pPkg::dataW-1:0]               wdata,
  input  logic [x2pPkg::strbW-1:0]               wstrb,
  // read address
  input  logic                                   arvalid,
  output logic                                   arready,
  input  logic [x2pPkg::addrW-1:0]               araddr,
  input  logic [x2pPkg::lenW-1:0]                arlen,
  input  logic [x2pPkg::idW-1:0]                 arid,
  input  logic [2:0]                             arprot,
  // read data
  output logic                                   rvalid,
  input  logic                                   rready,
  output logic [x2pPkg::dataW-1:0]               rdata,
  output x2pPkg::resp_t                          rresp,
  output logic [x2pPkg::idW-1:0]                 rid,
  output logic                                   rlast,
  // write response
  output logic                                   bvalid,
  input  logic                                   bready,
  output x2pPkg::resp_t                          bresp,
  output logic [x2pPkg::idW-1:0]                 bid,
  // APB
  output logic [slaveNum-1:0]                    psel,
  output logic                                   penable,
  output logic [x2pPkg::addrW-1:0]               paddr,
  output logic                                   pwrite,
  output logic [x2pPkg::dataW-1:0]               pwdata,
  output logic [x2pPkg::strbW-1:0]               pstrb,
  output logic [2:0]                             pprot,
  input  logic [slaveNum-1:0]                    pready,
  input  logic [slaveNum-1:0]                    pslverr,
  input  logic [slaveNum-1:0][x2pPkg::dataW-1:0] prdata
);

  import x2pPkg::*;

  axiReq_t             awIn, awHead;
  axiReq_t             arIn, arHead;
  wBeat_t              wIn, wHead;
  logic                awNotEmpty, arNotEmpty, wNotEmpty;
  logic                awPop, arPop, wPop;
  logic                beatStart, beatDone;
  apbBeat_t            beat;
  logic [slaveNum-1:0] slaveSel;
  logic                decErr;
  resp_t               beatResp;
  logic [dataW-1:0]    beatRdata;
  logic [idW-1:0]      burstId;
  logic                burstWrite, lastBeat;
  logic                rRoom, bFree;

  assign awIn = '{addr: awaddr, id: awid, len: awlen, prot: awprot};
  assign arIn = '{addr: araddr, id: arid, len: arlen, prot: arprot};
  assign wIn  = '{data: wdata, strb: wstrb};

  // ==========================================================================
  // AXI request queues
  // ==========================================================================

  syncFifo #(.fifoDepthLog2(fifoDepthLog2), .payload_t(axiReq_t)) awFifo (
    .pclk(pclk), .preset_n(preset_n),
    .push(awvalid & awready), .pop(awPop),
    .pushData(awIn), .popData(awHead),
    .notFull(awready), .notEmpty(awNotEmpty)
  );

  syncFifo #(.fifoDepthLog2(fifoDepthLog2), .payload_t(axiReq_t)) arFifo (
    .pclk(pclk), .preset_n(preset_n),
    .push(arvalid & arready), .pop(arPop),
    .pushData(arIn), .popData(arHead),
    .notFull(arready), .notEmpty(arNotEmpty)
  );

  syncFifo #(.fifoDepthLog2(fifoDepthLog2), .payload_t(wBeat_t)) wFifo (
    .pclk(pclk), .preset_n(preset_n),
    .push(wvalid & wready), .pop(wPop),
    .pushData(wIn), .popData(wHead),
    .notFull(wready), .notEmpty(wNotEmpty)
  );

  // ==========================================================================
  // beat path
  // ==========================================================================

  burstArbiter arbiter (
    .pclk(pclk), .preset_n(preset_n),
    .awHead(awHead), .awValid(awNotEmpty),
    .arHead(arHead), .arValid(arNotEmpty),
    .wHead(wHead), .wValid(wNotEmpty),
    .beatDone(beatDone), .rRoom(rRoom), .bFree(bFree),
    .awPop(awPop), .arPop(arPop), .wPop(wPop),
    .beatStart(beatStart), .beat(beat),
    .burstId(burstId), .burstWrite(burstWrite), .lastBeat(lastBeat)
  );

  addrDecoder #(
    .slaveNum(slaveNum), .slaveBase(slaveBase), .slaveSpan(slaveSpan)
  ) decoder (
    .addr(beat.addr), .slaveSel(slaveSel), .decErr(decErr)
  );

  apbMaster #(.slaveNum(slaveNum)) master (
    .pclk(pclk), .preset_n(preset_n),
    .beatStart(beatStart), .beat(beat),
    .slaveSel(slaveSel), .decErr(decErr),
    .pready(pready), .pslverr(pslverr), .prdata(prdata),
    .psel(psel), .penable(penable), .paddr(paddr), .pwrite(pwrite),
    .pwdata(pwdata), .pstrb(pstrb), .pprot(pprot),
    .beatDone(beatDone), .beatResp(beatResp), .beatRdata(beatRdata)
  );

  respBuilder #(.fifoDepthLog2(fifoDepthLog2)) results (
    .pclk(pclk), .preset_n(preset_n),
    .beatDone(beatDone), .beatResp(beatResp), .beatRdata(beatRdata),
    .burstId(burstId), .burstWrite(burstWrite), .lastBeat(lastBeat),
    .rready(rready), .bready(bready),
    .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rid(rid), .rlast(rlast),
    .bvalid(bvalid), .bresp(bresp), .bid(bid),
    .rRoom(rRoom), .bFree(bFree)
  );

endmodule

/* logic/respBuilder.sv */
`timescale 1ns/1ps

module respBuilder #(
  parameter int fifoDepthLog2 = 2
) (
  input  logic                    pclk,
  input  logic                    preset_n,
  input  logic                    beatDone,
  input  x2pPkg::resp_t           beatResp,
  input  logic [x2pPkg::dataW-1:0] beatRdata,
  input  logic [x2pPkg::idW-1:0]  burstId,
  input  logic                    burstWrite,
  input  logic                    lastBeat,
  input  logic                    rready,
  input  logic                    bready,
  output logic                    rvalid,
  output logic [x2pPkg::dataW-1:0] rdata,
  output x2pPkg::resp_t           rresp,
  output logic [x2pPkg::idW-1:0]  rid,
  output logic                    rlast,
  output logic                    bvalid,
  output x2pPkg::resp_t           bresp,
  output logic [x2pPkg::idW-1:0]  bid,
  output logic                    rRoom,
  output logic                    bFree
);

  import x2pPkg::*;

  rBeat_t rIn;
  rBeat_t rHead;
  resp_t  worst;
  resp_t  merged;

  assign rIn = '{data: beatRdata, resp: beatResp, id: burstId, last: lastBeat};

  // read beats wait here under R back-pressure
  syncFifo #(
    .fifoDepthLog2(fifoDepthLog2),
    .payload_t    (rBeat_t)
  ) rFifo (
    .pclk(pclk), .preset_n(preset_n),
    .push(beatDone & ~burstWrite), .pop(rvalid & rready),
    .pushData(rIn), .popData(rHead),
    .notFull(rRoom), .notEmpty(rvalid)
  );

  assign rdata = rHead.data;
  assign rresp = rHead.resp;
  assign rid   = rHead.id;
  assign rlast = rHead.last;

  // worst response seen so far in the write burst
  assign merged = (beatResp > worst) ? beatResp : worst;
  assign bFree  = ~bvalid;

  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      worst  <= OKAY;
      bvalid <= 1'b0;
    end else begin
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (beatDone && burstWrite) begin
        if (lastBeat) begin
          bvalid <= 1'b1;
          worst  <= OKAY;
        end else begin
          worst <= merged;
        end
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (beatDone && burstWrite && lastBeat) begin
      bresp <= merged;
      bid   <= burstId;
    end
  end

endmodule

/* logic/apbMaster.sv */
`timescale 1ns/1ps

module apbMaster #(
  parameter int slaveNum = 4
) (
  input  logic                                   pclk,
  input  logic                                   preset_n,
  input  logic                                   beatStart,
  input  x2pPkg::apbBeat_t                       beat,
  input  logic [slaveNum-1:0]                    slaveSel,
  input  logic                                   decErr,
  input  logic [slaveNum-1:0]                    pready,
  input  logic [slaveNum-1:0]                    pslverr,
  input  logic [slaveNum-1:0][x2pPkg::dataW-1:0] prdata,
  output logic [slaveNum-1:0]                    psel,
  output logic                                   penable,
  output logic [x2pPkg::addrW-1:0]               paddr,
  output logic                                   pwrite,
  output logic [x2pPkg::dataW-1:0]               pwdata,
  output logic [x2pPkg::strbW-1:0]               pstrb,
  output logic [2:0]                             pprot,
  output logic                                   beatDone,
  output x2pPkg::resp_t                          beatResp,
  output logic [x2pPkg::dataW-1:0]               beatRdata
);

  import x2pPkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } state_t;

  state_t state;
  logic   decErrQ;
  logic   selReady;
  logic   selErr;

  // ==========================================================================
  // selected slave return path
  // ==========================================================================

  // unmapped beat completes on its own after one ACCESS cycle
  assign selReady = decErrQ | (|(psel & pready));
  assign selErr   = |(psel & pslverr);

  always_comb begin
    beatRdata = '0;
    for (int i = 0; i < slaveNum; i++) begin
      if (psel[i]) begin
        beatRdata = beatRdata | prdata[i];
      end
    end
  end

  assign penable  = state == ACCESS;
  assign beatDone = penable & selReady;
  assign beatResp = decErrQ ? DECERR : (selErr ? SLVERR : OKAY);

  // ==========================================================================
  // IDLE / SETUP / ACCESS
  // ==========================================================================

  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      state   <= IDLE;
      psel    <= '0;
      decErrQ <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (beatStart) begin
            state   <= SETUP;
            psel    <= decErr ? '0 : slaveSel;
            decErrQ <= decErr;
          end
        end
        SETUP: begin
          state <= ACCESS;
        end
        ACCESS: begin
          // wait states until the selected slave is ready
          if (selReady) begin
            state   <= IDLE;
            psel    <= '0;
            decErrQ <= 1'b0;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // bus fields captured on entry to SETUP, held through ACCESS
  always_ff @(posedge pclk) begin
    if (state == IDLE && beatStart) begin
      paddr  <= beat.addr;
      pwrite <= beat.write;
      pwdata <= beat.wdata;
      pstrb  <= beat.strb;
      pprot  <= beat.prot;
    end
  end

endmodule

/* logic/addrDecoder.sv */
`timescale 1ns/1ps

module addrDecoder #(
  parameter int                       slaveNum  = 4,
  parameter logic [x2pPkg::addrW-1:0] slaveBase = 32'h4000_0000,
  parameter logic [x2pPkg::addrW-1:0] slaveSpan = 32'h0000_1000
) (
  input  logic [x2pPkg::addrW-1:0] addr,
  output logic [slaveNum-1:0]      slaveSel,
  output logic                     decErr
);

  import x2pPkg::*;

  // one extra bit so addresses below the base land far above every window
  logic [addrW:0] offset;
  logic [addrW:0] span;

  assign offset = {1'b0, addr} - {1'b0, slaveBase};
  assign span   = {1'b0, slaveSpan};

  // equal windows stacked from the base
  always_comb begin
    slaveSel = '0;
    for (int i = 0; i < slaveNum; i++) begin
      if (offset >= (addrW + 1)'(i) * span && offset < (addrW + 1)'(i + 1) * span) begin
        slaveSel[i] = 1'b1;
      end
    end
  end

  assign decErr = ~|slaveSel;

endmodule

/* logic/burstArbiter.sv */
`timescale 1ns/1ps

module burstArbiter (
  input  logic                    pclk,
  input  logic                    preset_n,
  input  x2pPkg::axiReq_t         awHead,
  input  logic                    awValid,
  input  x2pPkg::axiReq_t         arHead,
  input  logic                    arValid,
  input  x2pPkg::wBeat_t          wHead,
  input  logic                    wValid,
  input  logic                    beatDone,
  input  logic                    rRoom,
  input  logic                    bFree,
  output logic                    awPop,
  output logic                    arPop,
  output logic                    wPop,
  output logic                    beatStart,
  output x2pPkg::apbBeat_t        beat,
  output logic [x2pPkg::idW-1:0]  burstId,
  output logic                    burstWrite,
  output logic                    lastBeat
);

  import x2pPkg::*;

  logic             busy;
  logic             inFlight;
  logic [lenW-1:0]  remain;
  logic [addrW-1:0] curAddr;
  logic [2:0]       curProt;
  logic             canWrite;
  logic             canRead;
  logic             pickWrite;
  logic             pickRead;
  logic             startWrite;
  axiReq_t          head;

  // ==========================================================================
  // burst selection
  // ==========================================================================

  // a write needs its first W beat and a free B slot, a read needs R room
  assign canWrite  = awValid & wValid & bFree;
  assign canRead   = arValid & rRoom;
  // burstWrite keeps the last served direction
  assign pickWrite = ~busy & canWrite & (~canRead | ~burstWrite);
  assign pickRead  = ~busy & canRead & ~pickWrite;
  assign head      = pickWrite ? awHead : arHead;

  assign awPop = pickWrite;
  assign arPop = pickRead;

  // ==========================================================================
  // beat issue
  // ==========================================================================

  assign startWrite = busy ? burstWrite : pickWrite;
  assign beatStart  = busy ? (~inFlight & (burstWrite ? wValid : rRoom))
                           : (pickWrite | pickRead);
  assign wPop       = beatStart & startWrite;
  // remain counts the beats after the one on the bus
  assign lastBeat   = remain == '0;

  always_comb begin
    beat.addr  = busy ? curAddr : head.addr;
    beat.write = startWrite;
    beat.wdata = startWrite ? wHead.data : '0;
    beat.strb  = startWrite ? wHead.strb : '0;
    beat.prot  = busy ? curProt : head.prot;
  end

  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      busy       <= 1'b0;
      inFlight   <= 1'b0;
      burstWrite <= 1'b0;
      remain     <= '0;
    end else begin
      if (beatStart) begin
        inFlight <= 1'b1;
      end else if (beatDone) begin
        inFlight <= 1'b0;
      end
      if (pickWrite | pickRead) begin
        busy       <= 1'b1;
        burstWrite <= pickWrite;
        remain     <= head.len;
      end else begin
        if (beatStart) begin
          remain <= remain - lenW'(1);
        end
        if (beatDone && lastBeat) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // incrementing burst, one word per beat
  always_ff @(posedge pclk) begin
    if (beatStart) begin
      curAddr <= beat.addr + addrW'(strbW);
    end
    if (pickWrite | pickRead) begin
      burstId <= head.id;
      curProt <= head.prot;
    end
  end

endmodule

/* logic/syncFifo.sv */
`timescale 1ns/1ps

module syncFifo #(
  parameter int  fifoDepthLog2 = 2,
  parameter type payload_t     = logic [7:0]
) (
  input  logic     pclk,
  input  logic     preset_n,
  input  logic     push,
  input  logic     pop,
  input  payload_t pushData,
  output payload_t popData,
  output logic     notFull,
  output logic     notEmpty
);

  localparam int depth = 2 ** fifoDepthLog2;

  payload_t                 mem [depth];
  logic [fifoDepthLog2-1:0] wrPtr;
  logic [fifoDepthLog2-1:0] rdPtr;
  logic [fifoDepthLog2:0]   count;
  logic                     doPush;
  logic                     doPop;

  assign notFull  = count != (fifoDepthLog2 + 1)'(depth);
  assign notEmpty = count != '0;
  assign doPush   = push & notFull;
  assign doPop    = pop & notEmpty;
  // head stays visible until popped
  assign popData  = mem[rdPtr];

  always_ff @(posedge pclk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + fifoDepthLog2'(1);
      end
      if (doPop) begin
        rdPtr <= rdPtr + fifoDepthLog2'(1);
      end
      case ({doPush, doPop})
        2'b10:   count <= count + (fifoDepthLog2 + 1)'(1);
        2'b01:   count <= count - (fifoDepthLog2 + 1)'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

/* common/x2pPkg.sv */
package x2pPkg;

  localparam int addrW = 32;
  localparam int dataW = 32;
  localparam int strbW = 4;
  localparam int idW   = 8;
  localparam int lenW  = 8;

  // AXI encoding, numeric order follows severity
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  // queued AW or AR request, len is beats minus one
  typedef struct packed {
    logic [addrW-1:0] addr;
    logic [idW-1:0]   id;
    logic [lenW-1:0]  len;
    logic [2:0]       prot;
  } axiReq_t;

  typedef struct packed {
    logic [dataW-1:0] data;
    logic [strbW-1:0] strb;
  } wBeat_t;

  typedef struct packed {
    logic [dataW-1:0] data;
    resp_t            resp;
    logic [idW-1:0]   id;
    logic             last;
  } rBeat_t;

  // single APB transfer from arbiter to master
  typedef struct packed {
    logic [addrW-1:0] addr;
    logic             write;
    logic [dataW-1:0] wdata;
    logic [strbW-1:0] strb;
    logic [2:0]       prot;
  } apbBeat_t;

endpackage
